// File: shape_rasterizer.f
+incdir+include
logic/shape_pkg.sv
logic/raster_pkg.sv
logic/bresenham_controller.sv
logic/bresenham_line.sv
logic/layer_buffer.sv
logic/shape_rasterizer.sv
verif/tb_shape_rasterizer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shape rasterizer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f shape_rasterizer.f --top-module tb_shape_rasterizer -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation passed"
exit 0

// File: verif/tb_shape_rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "raster_defines.svh"

module tb_shape_rasterizer;
	import shape_pkg::*;
	import raster_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int SEED        = 53;
	localparam int N_DIR       = 12;  // Directed lines
	localparam int N_RLINE     = 4;   // Random lines
	localparam int N_TRI       = 10;  // Random triangles
	localparam int NUM_TESTS   = 1 + N_DIR + N_RLINE + N_TRI;  // Reset scan counts as one
	localparam int PIXELS      = `BUF_DIM * `BUF_DIM;
	localparam int TEST_CYCLES = 3 * 33 + 10 + PIXELS + 8;   // Worst shape plus full scan
	localparam int TIMEOUT_NS  = (NUM_TESTS * TEST_CYCLES + 200) * CLK_PERIOD;

	// {x0, y0, x1, y1} offsets, eight octants then flat, upright, dot and diagonal
	localparam logic [31:0] DIR_LINES [N_DIR] = '{
		32'h0000_1407, 32'h0000_0714, 32'h1400_0007, 32'h0700_0014,
		32'h0007_1400, 32'h0014_0700, 32'h1407_0000, 32'h0714_0000,
		32'h0005_1905, 32'h0300_031F, 32'h0909_0909, 32'h0000_1F1F
	};

	logic        clk = 1'b0;
	logic        n_rst;
	logic        bla_en;
	logic        tri_shape;
	vertex_set_t vertices;
	buf_addr_t   rd_x;
	buf_addr_t   rd_y;
	logic        rd_pixel;
	logic        bla_done;

	int    seed;
	int    errors     = 0;
	int    checks     = 0;
	int    shapes     = 0;     // Accepted starts, one bla_done each
	int    done_count = 0;     // bla_done cycles seen
	logic  done_prev  = 1'b0;
	logic  long_pulse = 1'b0;  // bla_done high two cycles running
	int    scan_req   = 0;     // Scan handshake with the compare process
	int    scan_ack   = 0;
	string test_name;
	logic [PIXELS-1:0] expected;  // Index y * BUF_DIM + x

	shape_rasterizer i_shape_rasterizer (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Counts bla_done and flags a pulse longer than one cycle, sampled mid-cycle
	always @(negedge clk) begin
		if (n_rst) begin
			if (bla_done)
				done_count <= done_count + 1;
			if (bla_done && done_prev)
				long_pulse <= 1'b1;
			done_prev <= bla_done;
		end
	end

	task automatic compare_values(input int got, input int exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	// Expected outline, minima moved to the origin, one Bresenham walk per edge
	function automatic logic [PIXELS-1:0] ref_image(input logic tri_s, input vertex_set_t v);
		logic [PIXELS-1:0] img;
		point_t pts [3];
		int mx, my, a, b, x, y, ex, ey;
		int dx, dy, sx, sy, err, e2;
		logic fin;
		img = '0;
		pts = '{v.v0, v.v1, v.v2};
		mx = int'(pts[0].x);
		my = int'(pts[0].y);
		for (int i = 1; i < (tri_s ? 3 : 2); i++) begin
			if (int'(pts[i].x) < mx) mx = int'(pts[i].x);
			if (int'(pts[i].y) < my) my = int'(pts[i].y);
		end
		for (int e = 0; e < (tri_s ? 3 : 1); e++) begin
			a = (e == 2) ? 1 : 0;  // Edges v0-v1, v0-v2, v1-v2
			b = (e == 0) ? 1 : 2;
			x = int'(pts[a].x) - mx;
			y = int'(pts[a].y) - my;
			ex = int'(pts[b].x) - mx;
			ey = int'(pts[b].y) - my;
			dx = (ex > x) ? ex - x : x - ex;
			dy = (ey > y) ? ey - y : y - ey;
			sx = (ex < x) ? -1 : 1;
			sy = (ey < y) ? -1 : 1;
			err = dx - dy;
			fin = 1'b0;
			while (!fin) begin
				if (x < `BUF_DIM && y < `BUF_DIM)  // Off-buffer points dropped
					img[y * `BUF_DIM + x] = 1'b1;
				fin = (x == ex) && (y == ey);
				if (!fin) begin
					e2 = 2 * err;
					if (e2 >= -dy) begin
						err = err - dy;
						x = x + sx;
					end
					if (e2 <= dx) begin
						err = err + dx;
						y = y + sy;
					end
				end
			end
		end
		return img;
	endfunction

	function automatic int rand_base();
		return int'($unsigned($random(seed)) % 225);  // Leaves room for a 31 pixel span
	endfunction

	function automatic coord_t rand_coord(input int base);
		return coord_t'(base + int'($unsigned($random(seed)) % 32));
	endfunction

	function automatic vertex_set_t random_shape();
		vertex_set_t v;
		int bx, by;
		bx = rand_base();
		by = rand_base();
		v.v0 = '{x: rand_coord(bx), y: rand_coord(by)};
		v.v1 = '{x: rand_coord(bx), y: rand_coord(by)};
		v.v2 = '{x: rand_coord(bx), y: rand_coord(by)};
		return v;
	endfunction

	task automatic run_scan();
		scan_req++;
		wait (scan_ack == scan_req);
	endtask

	task automatic draw_shape(input logic tri_s, input vertex_set_t v, input logic second_start);
		@(negedge clk);
		tri_shape = tri_s;
		vertices  = v;
		bla_en    = 1'b1;
		@(negedge clk);
		bla_en = 1'b0;
		shapes++;
		if (second_start) begin
			repeat (3) @(negedge clk);
			bla_en = 1'b1;  // Lands mid-draw
			@(negedge clk);
			bla_en = 1'b0;
		end
		while (!bla_done)
			@(negedge clk);
		@(negedge clk);  // bla_done back low before the scan
		expected = ref_image(tri_s, v);
		run_scan();
	endtask

	// Reads every pixel and compares with the reference image
	initial begin : compare_proc
		int err_start;
		rd_x = '0;
		rd_y = '0;
		forever begin
			wait (scan_req != scan_ack);
			err_start = errors;
			compare_values(int'(bla_done), 0, "bla_done low between shapes");
			for (int y = 0; y < `BUF_DIM; y++) begin
				for (int x = 0; x < `BUF_DIM; x++) begin
					@(negedge clk);
					rd_x = buf_addr_t'(x);
					rd_y = buf_addr_t'(y);
					@(posedge clk);
					compare_values(int'(rd_pixel), int'(expected[y * `BUF_DIM + x]),
						$sformatf("%s pixel x=%0d y=%0d", test_name, x, y));
				end
			end
			compare_values(done_count, shapes, "bla_done count");
			compare_values(int'(long_pulse), 0, "bla_done width");
			$display("test %0d %s: %s", scan_ack, test_name, (errors == err_start) ? "ok" : "mismatch");
			scan_ack++;
		end
	end

	initial begin : stimulus
		vertex_set_t v;
		logic [31:0] d;
		int bx, by;
		seed = SEED;
		n_rst = 1'b0;
		bla_en = 1'b0;
		tri_shape = 1'b0;
		vertices = '0;
		expected = '0;  // Empty layer right after reset
		test_name = "reset";
		repeat (5) @(negedge clk);
		n_rst = 1'b1;
		run_scan();
		for (int t = 0; t < N_DIR; t++) begin
			d = DIR_LINES[t];
			bx = rand_base();
			by = rand_base();
			v = random_shape();  // v2 left random, unused by a line
			v.v0 = '{x: coord_t'(bx) + d[31:24], y: coord_t'(by) + d[23:16]};
			v.v1 = '{x: coord_t'(bx) + d[15:8], y: coord_t'(by) + d[7:0]};
			test_name = $sformatf("directed line %0d", t);
			draw_shape(1'b0, v, t == N_DIR - 1);
		end
		for (int t = 0; t < N_RLINE; t++) begin
			test_name = $sformatf("random line %0d", t);
			draw_shape(1'b0, random_shape(), 1'b0);
		end
		for (int t = 0; t < N_TRI; t++) begin
			test_name = $sformatf("triangle %0d", t);
			draw_shape(1'b1, random_shape(), (t % 4) == 0);
		end
		$display("%0d tests run, %0d checks, %0d errors", scan_ack, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, bla_done never came", TIMEOUT_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/shape_rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

module shape_rasterizer (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   bla_en,     // Start pulse, ignored while busy
	input  logic                   tri_shape,  // Three vertices when high
	input  shape_pkg::vertex_set_t vertices,
	input  raster_pkg::buf_addr_t  rd_x,       // Pixel read address
	input  raster_pkg::buf_addr_t  rd_y,
	output logic                   rd_pixel,
	output logic                   bla_done    // One cycle when the outline is complete
);
	import shape_pkg::*;
	import raster_pkg::*;

	line_t     seg;        // Current edge, already translated
	logic      draw_en;
	logic      draw_done;
	logic      clear;
	pixel_wr_t pix_wr;

	// Sequencer, owns the shape and the edge order
	bresenham_controller i_bresenham_controller (
		.clk       (clk),
		.n_rst     (n_rst),
		.bla_en    (bla_en),
		.tri_shape (tri_shape),
		.vertices  (vertices),
		.draw_done (draw_done),
		.seg       (seg),
		.draw_en   (draw_en),
		.clear     (clear),
		.bla_done  (bla_done)
	);

	bresenham_line i_bresenham_line (
		.clk       (clk),
		.n_rst     (n_rst),
		.draw_en   (draw_en),
		.seg       (seg),
		.pix_wr    (pix_wr),
		.draw_done (draw_done)
	);

	// Bit-plane store, also read by the later fill stage
	layer_buffer i_layer_buffer (
		.clk      (clk),
		.n_rst    (n_rst),
		.clear    (clear),
		.pix_wr   (pix_wr),
		.rd_x     (rd_x),
		.rd_y     (rd_y),
		.rd_pixel (rd_pixel)
	);

endmodule

`default_nettype wire

// File: logic/layer_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "raster_defines.svh"

module layer_buffer (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  clear,     // Zeroes the whole layer
	input  raster_pkg::pixel_wr_t pix_wr,    // Sets one bit when valid
	input  raster_pkg::buf_addr_t rd_x,
	input  raster_pkg::buf_addr_t rd_y,
	output logic                  rd_pixel   // Addressed bit, combinational
);

	logic [`BUF_DIM-1:0][`BUF_DIM-1:0] layer;  // Indexed [row][column]
	logic [`BUF_DIM-1:0] row_hit;              // One-hot row select of the write

	// Row decode of the write strobe
	always_comb begin
		row_hit = '0;
		if (pix_wr.valid)
			row_hit[pix_wr.y] = 1'b1;
	end

	// One register row per line of the image
	for (genvar r = 0; r < `BUF_DIM; r++) begin : g_row
		always_ff @(posedge clk, negedge n_rst) begin
			if (!n_rst)
				layer[r] <= '0;
			else if (clear)                          // Clear wins over a write
				layer[r] <= '0;
			else if (row_hit[r])
				layer[r][pix_wr.x] <= 1'b1;          // Set only, edges merge
		end
	end

	assign rd_pixel = layer[rd_y][rd_x];

endmodule

`default_nettype wire

// File: logic/bresenham_line.sv
`timescale 1ns/1ps
`default_nettype none

`include "raster_defines.svh"

module bresenham_line (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic                  draw_en,    // Start level from the sequencer
	input  shape_pkg::line_t      seg,        // Latched when idle and draw_en is high
	output raster_pkg::pixel_wr_t pix_wr,     // One pixel per PLOT cycle
	output logic                  draw_done   // One cycle in FINISH
);
	import shape_pkg::*;
	import raster_pkg::*;

	localparam int ERR_W = `COORD_W + 3;  // Holds twice the error with sign

	line_state_t state, next_state;

	coord_t cur_x, cur_y;      // Point being emitted
	coord_t end_x, end_y;
	coord_t dx, dy;            // Absolute deltas
	logic step_xn, step_yn;    // Step towards smaller x / y
	logic signed [ERR_W-1:0] err;

	logic signed [ERR_W-1:0] e2, dx_e, dy_e, err_nx;
	coord_t nx_x, nx_y;
	logic at_end;

	assign dx_e   = $signed({{(ERR_W-`COORD_W){1'b0}}, dx});
	assign dy_e   = $signed({{(ERR_W-`COORD_W){1'b0}}, dy});
	assign e2     = err <<< 1;
	assign at_end = (cur_x == end_x) && (cur_y == end_y);

	// One Bresenham step from the current point
	always_comb begin
		err_nx = err;
		nx_x   = cur_x;
		nx_y   = cur_y;
		if (e2 >= -dy_e) begin
			err_nx = err_nx - dy_e;
			nx_x   = step_xn ? cur_x - 1'b1 : cur_x + 1'b1;
		end
		if (e2 <= dx_e) begin
			err_nx = err_nx + dx_e;
			nx_y   = step_yn ? cur_y - 1'b1 : cur_y + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			LN_IDLE:   if (draw_en) next_state = LN_PLOT;
			LN_PLOT:   if (at_end) next_state = LN_FINISH;  // End point goes out this cycle
			LN_FINISH: next_state = LN_IDLE;
			default:   next_state = LN_IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= LN_IDLE;
		else
			state <= next_state;
	end

	// Datapath, loaded on start and walked while plotting
	always_ff @(posedge clk) begin
		if (state == LN_IDLE && draw_en) begin
			cur_x   <= seg.p0.x;
			cur_y   <= seg.p0.y;
			end_x   <= seg.p1.x;
			end_y   <= seg.p1.y;
			step_xn <= seg.p1.x < seg.p0.x;
			step_yn <= seg.p1.y < seg.p0.y;
			dx      <= (seg.p1.x < seg.p0.x) ? seg.p0.x - seg.p1.x : seg.p1.x - seg.p0.x;
			dy      <= (seg.p1.y < seg.p0.y) ? seg.p0.y - seg.p1.y : seg.p1.y - seg.p0.y;
			err     <= $signed({{(ERR_W-`COORD_W){1'b0}}, (seg.p1.x < seg.p0.x) ?
				seg.p0.x - seg.p1.x : seg.p1.x - seg.p0.x}) -
				$signed({{(ERR_W-`COORD_W){1'b0}}, (seg.p1.y < seg.p0.y) ?
				seg.p0.y - seg.p1.y : seg.p1.y - seg.p0.y});  // dx - dy
		end else if (state == LN_PLOT && !at_end) begin
			cur_x <= nx_x;
			cur_y <= nx_y;
			err   <= err_nx;
		end
	end

	// Points past the buffer edge are walked but never written
	assign pix_wr.valid = (state == LN_PLOT) && (cur_x < `BUF_DIM) && (cur_y < `BUF_DIM);
	assign pix_wr.x     = cur_x[`BUF_AW-1:0];
	assign pix_wr.y     = cur_y[`BUF_AW-1:0];
	assign draw_done    = (state == LN_FINISH);

endmodule

`default_nettype wire

// File: logic/bresenham_controller.sv
`timescale 1ns/1ps
`default_nettype none

module bresenham_controller (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   bla_en,     // One cycle start pulse
	input  logic                   tri_shape,  // High for a triangle, low for a line
	input  shape_pkg::vertex_set_t vertices,   // Held stable until bla_done
	input  logic                   draw_done,  // Engine finished the current edge
	output shape_pkg::line_t       seg,        // Translated edge for the engine
	output logic                   draw_en,    // Level, high through each DRAW state
	output logic                   clear,      // Wipes the layer buffer
	output logic                   bla_done    // Shape complete, enables the fill stage
);
	import shape_pkg::*;
	import raster_pkg::*;

	ctrl_state_t state, next_state;

	coord_t min_x, min_y;    // Top-left corner of the bounding box
	coord_t cand_x, cand_y;  // Minima over the active vertices
	point_t pa, pb;          // Untranslated endpoints of the selected edge

	// Minimum search, v2 only counts for triangles
	always_comb begin
		cand_x = (vertices.v1.x < vertices.v0.x) ? vertices.v1.x : vertices.v0.x;
		cand_y = (vertices.v1.y < vertices.v0.y) ? vertices.v1.y : vertices.v0.y;
		if (tri_shape && (vertices.v2.x < cand_x))
			cand_x = vertices.v2.x;
		if (tri_shape && (vertices.v2.y < cand_y))
			cand_y = vertices.v2.y;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Minima only change in MIN_CALC
	always_ff @(posedge clk) begin
		if (state == MIN_CALC) begin
			min_x <= cand_x;
			min_y <= cand_y;
		end
	end

	always_comb begin
		next_state = state;
		draw_en    = 1'b0;
		clear      = 1'b0;
		bla_done   = 1'b0;
		pa         = vertices.v0;  // First edge is always v0 to v1
		pb         = vertices.v1;
		case (state)
			IDLE: begin
				if (bla_en)
					next_state = MIN_CALC;
			end
			MIN_CALC: next_state = CLEAR;
			CLEAR: begin
				clear      = 1'b1;
				next_state = tri_shape ? DRAW3_1 : DRAW2;
			end
			DRAW2: begin
				draw_en = 1'b1;
				if (draw_done)
					next_state = WAIT2;
			end
			WAIT2: next_state = DONE;  // Lets the engine settle back to idle
			DRAW3_1: begin
				draw_en = 1'b1;
				if (draw_done)
					next_state = WAIT3_1;
			end
			WAIT3_1: next_state = DRAW3_2;
			DRAW3_2: begin
				draw_en = 1'b1;
				pb      = vertices.v2;  // Edge v0 to v2
				if (draw_done)
					next_state = WAIT3_2;
			end
			WAIT3_2: next_state = DRAW3_3;
			DRAW3_3: begin
				draw_en = 1'b1;
				pa      = vertices.v1;  // Edge v1 to v2
				pb      = vertices.v2;
				if (draw_done)
					next_state = DONE;  // DONE already holds draw_en low
			end
			DONE: begin
				bla_done   = 1'b1;
				next_state = DONE_WAIT;
			end
			DONE_WAIT: next_state = IDLE;
			default: next_state = IDLE;
		endcase

		// Shift the edge to the top-left corner, zero outside DRAW
		seg = '0;
		if (draw_en) begin
			seg.p0.x = pa.x - min_x;
			seg.p0.y = pa.y - min_y;
			seg.p1.x = pb.x - min_x;
			seg.p1.y = pb.y - min_y;
		end
	end

endmodule

`default_nettype wire

// File: logic/raster_pkg.sv
`default_nettype none

`include "raster_defines.svh"

package raster_pkg;

	typedef logic [`BUF_AW-1:0] buf_addr_t;  // Row or column index into the layer

	// Pixel write strobe from the line engine
	typedef struct packed {
		logic      valid;
		buf_addr_t x;
		buf_addr_t y;
	} pixel_wr_t;

	// Shape sequencer states
	typedef enum logic [3:0] {
		IDLE, MIN_CALC, CLEAR, DRAW2, WAIT2, DRAW3_1, WAIT3_1,
		DRAW3_2, WAIT3_2, DRAW3_3, DONE, DONE_WAIT
	} ctrl_state_t;

	// Line engine states, prefixed to stay apart from the sequencer literals
	typedef enum logic [1:0] {
		LN_IDLE, LN_PLOT, LN_FINISH
	} line_state_t;

endpackage

`default_nettype wire

// File: logic/shape_pkg.sv
`default_nettype none

`include "raster_defines.svh"

package shape_pkg;

	typedef logic [`COORD_W-1:0] coord_t;  // One coordinate, unsigned

	// x sits in the low byte, same as the host coordinate bus
	typedef struct packed {
		coord_t y;
		coord_t x;
	} point_t;

	typedef struct packed {
		point_t p0;  // Start point
		point_t p1;  // End point
	} line_t;

	// v0 in the low bits, 48 bits in total
	typedef struct packed {
		point_t v2;
		point_t v1;
		point_t v0;
	} vertex_set_t;

endpackage

`default_nettype wire

// File: include/raster_defines.svh
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// Width of one vertex coordinate
`define COORD_W 8

// Side of the square layer buffer in pixels, power of two (16, 32 or 64)
`define BUF_DIM 32

// Address bits per buffer axis, log2 of BUF_DIM
`define BUF_AW 5

`endif
